// File: sim/serial_core_testdata.txt
// @00 program words, @20 load data for 0x100 upward, @28 fetch and store counts,
// @30 expected fetch addresses in order, @50 expected stores as address then data
@00
00500093 FFD00113 002081B3 20302023 40110233 20402223 10002283 20502423
0FF0A303 006283B3 20702623 001121B3 20302823 0020A1B3 20302A23 00708013
20002C23 00208463 00209463 00100193 00319463 00000663 20102E23 00000063
FE000CE3
@20
FFFFFFF0 00000020
@28
00000018 00000008
@30
00000000 00000004 00000008 0000000C 00000010 00000014 00000018 0000001C
00000020 00000024 00000028 0000002C 00000030 00000034 00000038 0000003C
00000040 00000044 00000048 00000050 00000054 00000060 00000058 0000005C
@50
00000200 00000002 00000204 FFFFFFF8
00000208 FFFFFFF0 0000020C 00000010
00000210 00000001 00000214 00000000
00000218 00000000 0000021C 00000005

// File: tb.f
+incdir+common
common/serial_ctrl_pkg.sv
common/core_bus_pkg.sv
logic/serial_state.sv
logic/instr_decode.sv
datapath/serial_alu.sv
datapath/serial_regfile.sv
datapath/serial_pc.sv
logic/serial_core.sv
sim/tb_serial_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the serial core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_serial_core \
   --Mdir obj_dir -o tb_serial_core
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_serial_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sim/tb_serial_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_defs.svh"

module tb_serial_core;

   import core_bus_pkg::*;

   logic                  i_clk      = 1'b0;
   logic                  i_rst      = 1'b1;
   logic                  i_ibus_ack = 1'b0;
   logic [`CORE_XLEN-1:0] i_ibus_rdt = '0;
   logic                  i_dbus_ack = 1'b0;
   logic [`CORE_XLEN-1:0] i_dbus_rdt = '0;
   ibus_req_t             o_ibus;
   dbus_req_t             o_dbus;

   // the raw image of the data file is split into the arrays below after loading
   logic [31:0] tdata      [0:127];
   logic [31:0] prog       [0:31];
   logic [31:0] load_mem   [0:7];
   logic [31:0] exp_fetch  [0:31];
   logic [31:0] exp_st_adr [0:15];
   logic [31:0] exp_st_dat [0:15];
   logic [31:0] n_fetch;
   logic [31:0] n_store;
   logic [4:0]  fetch_idx;
   logic [3:0]  store_idx;
   logic [31:0] ibus_delay;
   logic [31:0] dbus_delay;
   integer      seed     = 32'h4e7c;
   int          pass_cnt = 0;
   int          fail_cnt = 0;

   serial_core serial_core_inst (
      .i_clk, .i_rst, .i_ibus_ack, .i_ibus_rdt, .i_dbus_ack, .i_dbus_rdt,
      .o_ibus, .o_dbus);

   initial begin
      forever #20 i_clk = ~i_clk;
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         fail_cnt = fail_cnt + 1;
      end else begin
         $display("ok at %0t ns: %s = %h", $time, name, got);
         pass_cnt = pass_cnt + 1;
      end
   endtask

   // every ack of this memory model is a single-cycle pulse after 0 to 3 idle cycles
   always @(posedge i_clk) begin
      if (i_rst) begin
         i_ibus_ack <= 1'b0;
         i_dbus_ack <= 1'b0;
         ibus_delay <= 32'd0;
         dbus_delay <= 32'd0;
         fetch_idx  <= 5'd0;
         store_idx  <= 4'd0;
      end else begin
         i_ibus_ack <= 1'b0;
         i_dbus_ack <= 1'b0;
         // the request is still high in the ack cycle, so that cycle is skipped
         if (o_ibus.cyc && !i_ibus_ack) begin
            if (ibus_delay != 32'd0) begin
               ibus_delay <= ibus_delay - 32'd1;
            end else begin
               i_ibus_ack <= 1'b1;
               i_ibus_rdt <= prog[o_ibus.adr[6:2]];
               ibus_delay <= {$random(seed)} % 32'd4;
               compare_value($sformatf("o_ibus.adr (fetch %0d)", fetch_idx),
                             o_ibus.adr, exp_fetch[fetch_idx]);
               fetch_idx <= fetch_idx + 5'd1;
            end
         end
         // loads see their word in the same cycle as the ack
         if (o_dbus.cyc && !i_dbus_ack) begin
            if (dbus_delay != 32'd0) begin
               dbus_delay <= dbus_delay - 32'd1;
            end else begin
               i_dbus_ack <= 1'b1;
               i_dbus_rdt <= load_mem[o_dbus.adr[4:2]];
               dbus_delay <= {$random(seed)} % 32'd4;
               if (o_dbus.we) begin
                  if (store_idx == n_store[3:0]) begin
                     $display("store of %h to %h at %0t ns was not expected",
                              o_dbus.dat, o_dbus.adr, $time);
                     fail_cnt = fail_cnt + 1;
                  end else begin
                     compare_value($sformatf("o_dbus.adr (store %0d)", store_idx),
                                   o_dbus.adr, exp_st_adr[store_idx]);
                     compare_value($sformatf("o_dbus.dat (store %0d)", store_idx),
                                   o_dbus.dat, exp_st_dat[store_idx]);
                     store_idx <= store_idx + 4'd1;
                  end
               end
            end
         end
      end
   end

   initial begin
      $readmemh("sim/serial_core_testdata.txt", tdata);
      for (int i = 0; i < 32; i++) begin
         prog[i]      = tdata[i];
         exp_fetch[i] = tdata[48 + i];
      end
      for (int i = 0; i < 8; i++) begin
         load_mem[i] = tdata[32 + i];
      end
      // stores sit in the image as address and data pairs
      for (int i = 0; i < 16; i++) begin
         exp_st_adr[i] = tdata[80 + 2 * i];
         exp_st_dat[i] = tdata[81 + 2 * i];
      end
      n_fetch = tdata[40];
      n_store = tdata[41];
      repeat (10) @(posedge i_clk);
      i_rst <= 1'b0;
      // the last expected fetch comes after every store of the program
      wait (fetch_idx == n_fetch[4:0]);
      @(posedge i_clk);
      if (store_idx != n_store[3:0])
         $display("only %0d of %0d expected stores were seen", store_idx, n_store);
      $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && store_idx == n_store[3:0]) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // no instruction needs anywhere near 200 cycles, even with the longest ack waits
   initial begin
      @(negedge i_rst);
      repeat (n_fetch * 32'd200 + 32'd100) @(posedge i_clk);
      $display("timeout: the program did not reach its last fetch in time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/serial_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_defs.svh"

module serial_core (
   input  wire                       i_clk,
   input  wire                       i_rst,
   input  wire                       i_ibus_ack,
   input  wire [`CORE_XLEN-1:0]      i_ibus_rdt,
   input  wire                       i_dbus_ack,
   input  wire [`CORE_XLEN-1:0]      i_dbus_rdt,
   output core_bus_pkg::ibus_req_t   o_ibus,
   output core_bus_pkg::dbus_req_t   o_dbus
);

   import serial_ctrl_pkg::*;

   ctrl_t                 ctrl;
   cnt_t                  cnt;
   logic                  ibus_cyc;
   logic                  dbus_cyc;
   logic                  take_branch;
   logic                  rf_wen;
   logic                  imm_bit;
   logic                  rs1_bit;
   logic                  rs2_bit;
   logic                  res_bit;
   logic                  alu_cmp;
   logic [`CORE_XLEN-1:0] pc;
   logic [`CORE_XLEN-1:0] addr_buf;
   logic [`CORE_XLEN-1:0] store_dat;

   serial_state state_inst (
      .i_clk, .i_rst, .i_ctrl(ctrl), .i_ibus_ack, .i_dbus_ack, .i_alu_cmp(alu_cmp),
      .o_cnt(cnt), .o_ibus_cyc(ibus_cyc), .o_dbus_cyc(dbus_cyc),
      .o_take_branch(take_branch), .o_rf_wen(rf_wen));

   instr_decode decode_inst (
      .i_clk, .i_rst, .i_ibus_ack, .i_ibus_rdt, .i_cnt(cnt),
      .i_stage_two(cnt.stage_two), .o_ctrl(ctrl), .o_imm_bit(imm_bit));

   serial_alu alu_inst (
      .i_clk, .i_rst, .i_cnt(cnt), .i_ctrl(ctrl), .i_rs1_bit(rs1_bit),
      .i_rs2_bit(rs2_bit), .i_imm_bit(imm_bit), .o_res_bit(res_bit), .o_cmp(alu_cmp));

   serial_regfile regfile_inst (
      .i_clk, .i_rst, .i_ctrl(ctrl), .i_cnt(cnt), .i_wen(rf_wen), .i_wr_bit(res_bit),
      .i_dbus_ack, .i_dbus_rdt, .o_rs1_bit(rs1_bit), .o_rs2_bit(rs2_bit));

   serial_pc pc_inst (
      .i_clk, .i_rst, .i_cnt(cnt), .i_ctrl(ctrl), .i_take_branch(take_branch),
      .i_imm_bit(imm_bit), .i_alu_bit(res_bit), .i_rs2_bit(rs2_bit),
      .o_pc(pc), .o_buf(addr_buf), .o_store_dat(store_dat));

   assign o_ibus = '{cyc: ibus_cyc, adr: pc};

   // only word accesses exist, so the two low address bits are forced to zero
   assign o_dbus = '{cyc: dbus_cyc,
                     we:  ctrl.store_op,
                     adr: {addr_buf[`CORE_XLEN-1:2], 2'b00},
                     dat: store_dat};

endmodule

`default_nettype wire

// File: datapath/serial_pc.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_defs.svh"

module serial_pc (
   input  wire                         i_clk,
   input  wire                         i_rst,
   input  wire serial_ctrl_pkg::cnt_t  i_cnt,
   input  wire serial_ctrl_pkg::ctrl_t i_ctrl,
   input  wire                         i_take_branch,
   input  wire                         i_imm_bit,
   input  wire                         i_alu_bit,
   input  wire                         i_rs2_bit,
   output logic [`CORE_XLEN-1:0]       o_pc,
   output logic [`CORE_XLEN-1:0]       o_buf,
   output logic [`CORE_XLEN-1:0]       o_store_dat
);

   // delays cnt0 by two counts to mark bit 2 for the plus-four step
   logic [1:0] four_sr;
   logic       add_bit;
   logic       pc_cin;
   logic       pc_sum;
   logic       pc_carry;

   assign add_bit = i_take_branch ? i_imm_bit : four_sr[1];
   assign pc_cin  = i_cnt.cnt0 ? 1'b0 : pc_carry;
   assign pc_sum  = o_pc[0] ^ add_bit ^ pc_cin;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         four_sr  <= 2'b00;
         pc_carry <= 1'b0;
         o_pc     <= `CORE_RESET_PC;
      end else begin
         if (i_cnt.cnt_en)
            four_sr <= {four_sr[0], i_cnt.cnt0};
         // the pc shifts through itself, so it reads as the new address after bit 31
         if (i_cnt.pc_en) begin
            o_pc     <= {pc_sum, o_pc[`CORE_XLEN-1:1]};
            pc_carry <= (o_pc[0] & add_bit) | (pc_cin & (o_pc[0] ^ add_bit));
         end
      end
   end

   // stage one of lw and sw builds the address and the store word side by side
   always_ff @(posedge i_clk) begin
      if (i_cnt.cnt_en & i_cnt.init & i_ctrl.mem_op) begin
         o_buf       <= {i_alu_bit, o_buf[`CORE_XLEN-1:1]};
         o_store_dat <= {i_rs2_bit, o_store_dat[`CORE_XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

// File: datapath/serial_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_defs.svh"

module serial_regfile (
   input  wire                         i_clk,
   input  wire                         i_rst,
   input  wire serial_ctrl_pkg::ctrl_t i_ctrl,
   input  wire serial_ctrl_pkg::cnt_t  i_cnt,
   input  wire                         i_wen,
   input  wire                         i_wr_bit,
   input  wire                         i_dbus_ack,
   input  wire [`CORE_XLEN-1:0]        i_dbus_rdt,
   output logic                        o_rs1_bit,
   output logic                        o_rs2_bit
);

   // x0 has no storage, it always reads as zero
   logic [`CORE_XLEN-1:0] regs [1:`CORE_NREGS-1];
   logic [`CORE_XLEN-1:0] ld_sr;
   logic                  wr_bit;

   // a load writes back the captured word, everything else takes the alu bit
   assign wr_bit = i_ctrl.mem_op ? ld_sr[0] : i_wr_bit;

   always_comb begin
      o_rs1_bit = 1'b0;
      o_rs2_bit = 1'b0;
      for (int i = 1; i < `CORE_NREGS; i++) begin
         if (i_ctrl.rs1_addr == 3'(i))
            o_rs1_bit = regs[i][0];
         if (i_ctrl.rs2_addr == 3'(i))
            o_rs2_bit = regs[i][0];
      end
   end

   // source registers rotate so 32 cycles restore them, rd takes new bits at the top
   always_ff @(posedge i_clk) begin
      for (int i = 1; i < `CORE_NREGS; i++) begin
         if (i_cnt.cnt_en) begin
            if (i_wen & (i_ctrl.rd_addr == 3'(i)))
               regs[i] <= {wr_bit, regs[i][`CORE_XLEN-1:1]};
            else if ((i_ctrl.rs1_addr == 3'(i)) | (i_ctrl.rs2_addr == 3'(i)))
               regs[i] <= {regs[i][0], regs[i][`CORE_XLEN-1:1]};
         end
      end
   end

   // read data is only valid in the ack cycle, so it is caught here and fed out in stage two
   always_ff @(posedge i_clk) begin
      if (i_dbus_ack)
         ld_sr <= i_dbus_rdt;
      else if (i_cnt.cnt_en & i_cnt.stage_two)
         ld_sr <= {1'b0, ld_sr[`CORE_XLEN-1:1]};
   end

   wen_counting_a: assert property (@(posedge i_clk) disable iff (i_rst)
      i_wen |-> i_cnt.cnt_en);

endmodule

`default_nettype wire

// File: datapath/serial_alu.sv
`timescale 1ns/1ns
`default_nettype none

module serial_alu (
   input  wire                         i_clk,
   input  wire                         i_rst,
   input  wire serial_ctrl_pkg::cnt_t  i_cnt,
   input  wire serial_ctrl_pkg::ctrl_t i_ctrl,
   input  wire                         i_rs1_bit,
   input  wire                         i_rs2_bit,
   input  wire                         i_imm_bit,
   output logic                        o_res_bit,
   output logic                        o_cmp
);

   logic op_b;
   logic b_inv;
   logic c_in;
   logic c_out;
   logic sum;
   logic carry_r;
   logic eq_r;
   logic eq_now;
   logic lt_now;
   logic cmp_r;

   assign op_b  = i_ctrl.use_imm ? i_imm_bit : i_rs2_bit;
   // subtract is add of the inverted operand with a carry of one at bit 0
   assign b_inv = op_b ^ i_ctrl.sub_op;
   assign c_in  = i_cnt.cnt0 ? i_ctrl.sub_op : carry_r;
   assign sum   = i_rs1_bit ^ b_inv ^ c_in;
   assign c_out = (i_rs1_bit & b_inv) | (c_in & (i_rs1_bit ^ b_inv));

   // equality restarts at cnt0 and stays set only while every bit matched
   assign eq_now = (i_cnt.cnt0 | eq_r) & !(i_rs1_bit ^ op_b);
   // at bit 31 differing signs decide directly, otherwise the difference sign does
   assign lt_now = (i_rs1_bit ^ op_b) ? i_rs1_bit : sum;

   // only meaningful on the cnt_done cycle of stage one
   assign o_cmp = i_ctrl.slt_op ? lt_now : eq_now;

   // slt writes its latched compare into bit 0 and zeros above it
   assign o_res_bit = (i_ctrl.slt_op & i_cnt.stage_two) ? (i_cnt.cnt0 & cmp_r) : sum;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
         eq_r    <= 1'b0;
         cmp_r   <= 1'b0;
      end else begin
         if (i_cnt.cnt_en) begin
            carry_r <= c_out;
            eq_r    <= eq_now;
         end
         if (i_cnt.cnt_done & !i_cnt.stage_two)
            cmp_r <= o_cmp;
      end
   end

endmodule

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_defs.svh"

module instr_decode (
   input  wire                         i_clk,
   input  wire                         i_rst,
   input  wire                         i_ibus_ack,
   input  wire [`CORE_XLEN-1:0]        i_ibus_rdt,
   input  wire serial_ctrl_pkg::cnt_t  i_cnt,
   input  wire                         i_stage_two,
   output serial_ctrl_pkg::ctrl_t      o_ctrl,
   output logic                        o_imm_bit
);

   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;

   logic [`CORE_XLEN-1:0] ir;
   // twelve immediate bits plus one sign copy, b-type keeps a zero lsb
   logic [12:0]           imm_r;
   logic [12:0]           imm_new;
   logic [6:0]            rdt_opc;
   logic                  rdt_ok;
   logic                  is_reg;
   logic                  is_load;
   logic                  is_store;
   logic                  is_branch;
   logic                  is_slt;

   assign rdt_opc = i_ibus_rdt[6:0];
   assign rdt_ok  = rdt_opc inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH};

   // immediate is taken straight from the bus word so it is ready at cnt0
   always_comb begin
      if (rdt_opc == OP_BRANCH)
         imm_new = {i_ibus_rdt[31], i_ibus_rdt[7], i_ibus_rdt[30:25],
                    i_ibus_rdt[11:8], 1'b0};
      else if (rdt_opc == OP_STORE)
         imm_new = {i_ibus_rdt[31], i_ibus_rdt[31:25], i_ibus_rdt[11:7]};
      else
         imm_new = {i_ibus_rdt[31], i_ibus_rdt[31:20]};
   end

   always_ff @(posedge i_clk) begin
      if (i_rst)
         ir <= '0;
      else if (i_ibus_ack)
         ir <= i_ibus_rdt;
   end

   // branches consume the offset in stage two, everything else in stage one
   always_ff @(posedge i_clk) begin
      if (i_ibus_ack)
         imm_r <= imm_new;
      else if (i_cnt.cnt_en & (o_ctrl.branch_op == i_stage_two))
         imm_r <= {imm_r[12], imm_r[12:1]};
   end

   assign o_imm_bit = imm_r[0];

   assign is_reg    = ir[6:0] == OP_REG;
   assign is_load   = ir[6:0] == OP_LOAD;
   assign is_store  = ir[6:0] == OP_STORE;
   assign is_branch = ir[6:0] == OP_BRANCH;
   assign is_slt    = is_reg & (ir[14:12] == 3'b010);

   // slt and the branches subtract to get their compare, funct7 bit 30 selects sub
   assign o_ctrl = '{rd_addr:   ir[9:7],
                     rs1_addr:  ir[17:15],
                     rs2_addr:  ir[22:20],
                     two_stage: is_load | is_store | is_branch | is_slt,
                     branch_op: is_branch,
                     bne_op:    is_branch & ir[12],
                     mem_op:    is_load | is_store,
                     store_op:  is_store,
                     sub_op:    is_branch | (is_reg & (ir[30] | ir[13])),
                     slt_op:    is_slt,
                     use_imm:   (ir[6:0] == OP_IMM) | is_load | is_store,
                     rd_op:     is_reg | (ir[6:0] == OP_IMM) | is_load};

   // the memory only ever returns the supported subset
   opcode_ok_a: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ibus_ack |-> rdt_ok);

endmodule

`default_nettype wire

// File: logic/serial_state.sv
`timescale 1ns/1ns
`default_nettype none

module serial_state (
   input  wire                         i_clk,
   input  wire                         i_rst,
   input  wire serial_ctrl_pkg::ctrl_t i_ctrl,
   input  wire                         i_ibus_ack,
   input  wire                         i_dbus_ack,
   input  wire                         i_alu_cmp,
   output serial_ctrl_pkg::cnt_t       o_cnt,
   output logic                        o_ibus_cyc,
   output logic                        o_dbus_cyc,
   output logic                        o_take_branch,
   output logic                        o_rf_wen
);

   // upper three bits of the 0..31 bit index
   logic [2:0] cnt_hi;
   // rotating one-hot stands in for the two low index bits
   logic [3:0] cnt_r;
   logic       init_done;
   logic       cnt_en;
   logic       cnt0;
   logic       cnt_done;
   logic       init;
   logic       pc_en;
   logic       start;

   // the counter runs whenever a bit sits anywhere in the one-hot ring
   assign cnt_en   = |cnt_r;
   assign cnt0     = (cnt_hi == 3'd0) & cnt_r[0];
   assign cnt_done = (cnt_hi == 3'd7) & cnt_r[3];

   // init is set in stage one of a two-stage instruction and cleared once that stage has run
   assign init  = i_ctrl.two_stage & !init_done;
   // the pc only moves in the last stage of an instruction
   assign pc_en = cnt_en & !init;

   // memory access sits in the gap between the two stages
   assign o_dbus_cyc = !cnt_en & init_done & i_ctrl.mem_op;

   // a count starts after a fetch, right after stage one of slt and branches,
   // or after the data bus has answered
   assign start = (o_ibus_cyc & i_ibus_ack) |
                  (cnt_done & init & !i_ctrl.mem_op) |
                  (o_dbus_cyc & i_dbus_ack);

   // rd is written in the only stage of alu ops and in stage two of lw and slt
   assign o_rf_wen = pc_en & i_ctrl.rd_op;

   assign o_cnt = '{cnt_en:    cnt_en,
                    init:      init,
                    cnt0:      cnt0,
                    cnt_done:  cnt_done,
                    stage_two: init_done,
                    pc_en:     pc_en};

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt_hi <= 3'd0;
         cnt_r  <= 4'b0000;
      end else begin
         // the high part steps each time the one-hot bit leaves position 3
         cnt_hi <= cnt_hi + {2'b00, cnt_r[3]};
         // cnt_done blocks the wrap so the ring empties unless a new start arrives
         cnt_r  <= {cnt_r[2:0], (cnt_r[3] & !cnt_done) | start};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         // the first fetch goes out as soon as reset is released
         o_ibus_cyc    <= 1'b1;
         init_done     <= 1'b0;
         o_take_branch <= 1'b0;
      end else begin
         // the next fetch follows the last count that updated the pc
         if (cnt_done)
            o_ibus_cyc <= pc_en;
         else if (i_ibus_ack)
            o_ibus_cyc <= 1'b0;
         if (cnt_done) begin
            init_done <= init;
            // the compare is only settled on the last bit of stage one
            o_take_branch <= init & i_ctrl.branch_op & (i_alu_cmp ^ i_ctrl.bne_op);
         end
      end
   end

   // a fetch is never outstanding while the datapath is shifting
   ibus_idle_a: assert property (@(posedge i_clk) disable iff (i_rst)
      o_ibus_cyc |-> !cnt_en);

   // once raised, the data request stays up until the memory answers it
   dbus_hold_a: assert property (@(posedge i_clk) disable iff (i_rst)
      o_dbus_cyc & !i_dbus_ack |=> o_dbus_cyc);

endmodule

`default_nettype wire

// File: common/core_bus_pkg.sv
`default_nettype none

`include "core_defs.svh"

package core_bus_pkg;

   // instruction fetch request, adr is always the current pc
   typedef struct packed {
      logic                  cyc;
      logic [`CORE_XLEN-1:0] adr;
   } ibus_req_t;

   // data request, dat only matters when we is set
   typedef struct packed {
      logic                  cyc;
      logic                  we;
      logic [`CORE_XLEN-1:0] adr;
      logic [`CORE_XLEN-1:0] dat;
   } dbus_req_t;

endpackage

`default_nettype wire

// File: common/serial_ctrl_pkg.sv
`default_nettype none

package serial_ctrl_pkg;

   // decoded instruction, held stable for the whole instruction
   typedef struct packed {
      logic [2:0] rd_addr;
      logic [2:0] rs1_addr;
      logic [2:0] rs2_addr;
      // set for lw, sw, slt and the branches
      logic       two_stage;
      logic       branch_op;
      logic       bne_op;
      logic       mem_op;
      logic       store_op;
      // the alu inverts the second operand and seeds a carry of one
      logic       sub_op;
      logic       slt_op;
      logic       use_imm;
      logic       rd_op;
   } ctrl_t;

   // counter state shared by every serial block
   typedef struct packed {
      logic cnt_en;
      logic init;
      logic cnt0;
      logic cnt_done;
      logic stage_two;
      logic pc_en;
   } cnt_t;

endpackage

`default_nettype wire

// File: common/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// width of every register and of both bus words, one bit moves per counted cycle
`define CORE_XLEN 32

// only x0 through x7 are implemented, the upper register field bits are ignored
`define CORE_NREGS 8

// address of the first fetch once reset is released
`define CORE_RESET_PC 32'h0000_0000

`endif
